// File: source/eth_na_pkg.sv
// shared types of the adapter; Wishbone and AXI4-Lite carry whole 32-bit words only, no byte lanes
package eth_na_pkg;

   localparam int DATA_W           = 32;
   localparam int ADDR_W           = 32;
   localparam int NIBBLES_PER_WORD = 8;     // MII transfers per word

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axi_resp_e;

   typedef enum logic [2:0] {
      IDLE,
      WRITE,
      WRITE_RESP,
      READ,
      READ_DATA,
      DONE
   } bridge_state_e;

   // register offsets, low address byte
   typedef enum logic [7:0] {
      REG_ISR     = 8'h00,
      REG_IER     = 8'h04,
      REG_TX_VAC  = 8'h0C,
      REG_TX_DATA = 8'h10,
      REG_TX_LAST = 8'h14,
      REG_RX_OCC  = 8'h1C,
      REG_RX_DATA = 8'h20
   } reg_addr_e;

   localparam int ISR_RX_DONE = 0;
   localparam int ISR_TX_DONE = 1;
   localparam int ISR_RX_OVF  = 2;

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic              err;
      logic [DATA_W-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic [ADDR_W-1:0] awaddr;
      logic              awvalid;
      logic [DATA_W-1:0] wdata;
      logic              wvalid;
      logic              bready;
      logic [ADDR_W-1:0] araddr;
      logic              arvalid;
      logic              rready;
   } axil_req_t;

   typedef struct packed {
      logic              awready;
      logic              wready;
      axi_resp_e         bresp;
      logic              bvalid;
      logic              arready;
      logic [DATA_W-1:0] rdata;
      axi_resp_e         rresp;
      logic              rvalid;
   } axil_rsp_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } axis_word_t;

endpackage

// File: source/sync_fifo.sv
// DEPTH must be at least 2; the caller must not push while full or pop while empty
`timescale 1ns/1ps

module sync_fifo #(
   parameter int DEPTH = 16
) (
   input  logic                         sys_clk_i,
   input  logic                         rst_n_i,
   input  logic                         push_i,
   input  eth_na_pkg::axis_word_t       push_word_i,
   input  logic                         pop_i,
   output eth_na_pkg::axis_word_t       head_o,
   output logic                         full_o,
   output logic                         empty_o,
   output logic [$clog2(DEPTH+1)-1:0]   count_o
);

   localparam int PTR_W = $clog2(DEPTH);

   eth_na_pkg::axis_word_t mem [DEPTH];
   logic [PTR_W-1:0]       wr_ptr_q, rd_ptr_q;

   assign head_o  = mem[rd_ptr_q];              // show-ahead
   assign full_o  = (count_o == DEPTH);
   assign empty_o = (count_o == '0);

   always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_o  <= '0;
      end else begin
         if (push_i)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop_i)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         count_o <= count_o + push_i - pop_i;
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (push_i)
         mem[wr_ptr_q] <= push_word_i;
   end

   assert property (@(posedge sys_clk_i) disable iff (!rst_n_i) !(push_i && full_o));
   assert property (@(posedge sys_clk_i) disable iff (!rst_n_i) !(pop_i && empty_o));

endmodule

// File: source/wb_axil_bridge.sv
// single classic Wishbone transfers only; the master holds its request until ack or err
`timescale 1ns/1ps

module wb_axil_bridge (
   input  logic                  sys_clk_i,
   input  logic                  rst_n_i,
   input  eth_na_pkg::wb_req_t   wb_req_i,
   output eth_na_pkg::wb_rsp_t   wb_rsp_o,
   output eth_na_pkg::axil_req_t axil_req_o,
   input  eth_na_pkg::axil_rsp_t axil_rsp_i
);

   eth_na_pkg::bridge_state_e     state_q;
   eth_na_pkg::bridge_state_e     state_d;
   eth_na_pkg::axi_resp_e         resp_q;
   logic [eth_na_pkg::DATA_W-1:0] rdata_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         eth_na_pkg::IDLE:
            if (wb_req_i.cyc && wb_req_i.stb)
               state_d = wb_req_i.we ? eth_na_pkg::WRITE : eth_na_pkg::READ;
         eth_na_pkg::WRITE:
            if (axil_rsp_i.awready && axil_rsp_i.wready)
               state_d = eth_na_pkg::WRITE_RESP;   // AW and W go together
         eth_na_pkg::WRITE_RESP:
            if (axil_rsp_i.bvalid)
               state_d = eth_na_pkg::DONE;
         eth_na_pkg::READ:
            if (axil_rsp_i.arready)
               state_d = eth_na_pkg::READ_DATA;
         eth_na_pkg::READ_DATA:
            if (axil_rsp_i.rvalid)
               state_d = eth_na_pkg::DONE;
         default:
            state_d = eth_na_pkg::IDLE;          // one response cycle
      endcase
   end

   always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= eth_na_pkg::IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (state_q == eth_na_pkg::WRITE_RESP && axil_rsp_i.bvalid) begin
         resp_q <= axil_rsp_i.bresp;
      end
      if (state_q == eth_na_pkg::READ_DATA && axil_rsp_i.rvalid) begin
         resp_q  <= axil_rsp_i.rresp;
         rdata_q <= axil_rsp_i.rdata;
      end
   end

   always_comb begin
      axil_req_o         = '0;
      axil_req_o.awaddr  = wb_req_i.adr;
      axil_req_o.wdata   = wb_req_i.dat;
      axil_req_o.araddr  = wb_req_i.adr;
      axil_req_o.awvalid = (state_q == eth_na_pkg::WRITE);
      axil_req_o.wvalid  = (state_q == eth_na_pkg::WRITE);
      axil_req_o.bready  = (state_q == eth_na_pkg::WRITE_RESP);
      axil_req_o.arvalid = (state_q == eth_na_pkg::READ);
      axil_req_o.rready  = (state_q == eth_na_pkg::READ_DATA);
   end

   always_comb begin
      wb_rsp_o.ack = (state_q == eth_na_pkg::DONE) && (resp_q == eth_na_pkg::OKAY);
      wb_rsp_o.err = (state_q == eth_na_pkg::DONE) && (resp_q != eth_na_pkg::OKAY);
      wb_rsp_o.dat = rdata_q;
   end

   // valids hold until the slave takes them
   assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      axil_req_o.awvalid && !axil_rsp_i.awready |=> axil_req_o.awvalid);
   assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      axil_req_o.wvalid && !axil_rsp_i.wready |=> axil_req_o.wvalid);
   assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      axil_req_o.arvalid && !axil_rsp_i.arready |=> axil_req_o.arvalid);
   assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      !(wb_rsp_o.ack && wb_rsp_o.err));

endmodule

// File: source/mii_tx.sv
// MII transmit on sys_clk_i without preamble or FCS; tx_valid_i must stay high through a frame
`timescale 1ns/1ps

module mii_tx (
   input  logic                   sys_clk_i,
   input  logic                   rst_n_i,
   input  eth_na_pkg::axis_word_t tx_word_i,
   input  logic                   tx_valid_i,
   output logic                   tx_ready_o,
   output logic                   tx_done_o,
   output logic [3:0]             mii_txd_o,
   output logic                   mii_tx_en_o
);

   localparam int               CNT_W    = $clog2(eth_na_pkg::NIBBLES_PER_WORD);
   localparam logic [CNT_W-1:0] LAST_NIB = CNT_W'(eth_na_pkg::NIBBLES_PER_WORD - 1);

   logic [eth_na_pkg::DATA_W-1:0] shift_q;
   logic [CNT_W-1:0]              nib_q;
   logic                          busy_q, last_q, done_q, end_of_word, accept;

   assign end_of_word = busy_q && (nib_q == LAST_NIB);
   // idle, or on the final nibble of a word that is not the frame's last
   assign tx_ready_o  = !done_q && (!busy_q || (end_of_word && !last_q));
   assign accept      = tx_valid_i && tx_ready_o;
   assign mii_txd_o   = shift_q[3:0];               // least significant nibble first
   assign mii_tx_en_o = busy_q;
   assign tx_done_o   = done_q;                     // doubles as the inter-frame gap

   always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         last_q <= 1'b0;
         done_q <= 1'b0;
         nib_q  <= '0;
      end else begin
         done_q <= end_of_word && last_q;
         if (accept) begin
            busy_q <= 1'b1;
            last_q <= tx_word_i.last;
            nib_q  <= '0;
         end else if (end_of_word) begin
            busy_q <= 1'b0;
         end else if (busy_q) begin
            nib_q <= nib_q + 1'b1;
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (accept)
         shift_q <= tx_word_i.data;
      else if (busy_q)
         shift_q <= shift_q >> 4;
   end

   assert property (@(posedge sys_clk_i) disable iff (!rst_n_i) !$isunknown(mii_tx_en_o));

endmodule

// File: source/mii_rx.sv
// MII receive on sys_clk_i; every rx_dv pulse is one frame, a trailing partial word is zero-padded
`timescale 1ns/1ps

module mii_rx (
   input  logic                   sys_clk_i,
   input  logic                   rst_n_i,
   input  logic [3:0]             mii_rxd_i,
   input  logic                   mii_rx_dv_i,
   output eth_na_pkg::axis_word_t rx_word_o,
   output logic                   rx_valid_o
);

   localparam int               CNT_W    = $clog2(eth_na_pkg::NIBBLES_PER_WORD);
   localparam logic [CNT_W-1:0] LAST_NIB = CNT_W'(eth_na_pkg::NIBBLES_PER_WORD - 1);

   logic [eth_na_pkg::DATA_W-1:0] asm_q;
   logic [CNT_W-1:0]              nib_q;
   logic                          full_q, dv_q, valid_q, fall;
   eth_na_pkg::axis_word_t        word_q;

   assign fall       = dv_q && !mii_rx_dv_i;
   assign rx_word_o  = word_q;
   assign rx_valid_o = valid_q;

   always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dv_q    <= 1'b0;
         valid_q <= 1'b0;
         full_q  <= 1'b0;
         nib_q   <= '0;
      end else begin
         dv_q    <= mii_rx_dv_i;
         valid_q <= 1'b0;
         if (mii_rx_dv_i) begin
            valid_q <= full_q;                        // held word is not the last
            full_q  <= (nib_q == LAST_NIB);
            nib_q   <= (nib_q == LAST_NIB) ? '0 : nib_q + 1'b1;
         end else if (fall) begin
            valid_q <= full_q || (nib_q != '0);       // flush with last
            full_q  <= 1'b0;
            nib_q   <= '0;
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (mii_rx_dv_i) begin
         if (full_q)
            word_q <= '{data: asm_q, last: 1'b0};
         if (nib_q == '0)
            asm_q <= eth_na_pkg::DATA_W'(mii_rxd_i);  // new word, upper nibbles cleared
         else
            asm_q[nib_q*4 +: 4] <= mii_rxd_i;
      end else if (fall) begin
         word_q <= '{data: asm_q, last: 1'b1};
      end
   end

endmodule

// File: source/axil_stream_fifo.sv
// decodes only the low address byte; writes to read-only offsets answer SLVERR like unmapped ones
`timescale 1ns/1ps

module axil_stream_fifo #(
   parameter int TX_DEPTH = 32,
   parameter int RX_DEPTH = 16
) (
   input  logic                   sys_clk_i,
   input  logic                   rst_n_i,
   input  eth_na_pkg::axil_req_t  axil_req_i,
   output eth_na_pkg::axil_rsp_t  axil_rsp_o,
   output eth_na_pkg::axis_word_t tx_word_o,
   output logic                   tx_valid_o,
   input  logic                   tx_ready_i,
   input  logic                   tx_done_i,
   input  eth_na_pkg::axis_word_t rx_word_i,
   input  logic                   rx_valid_i,
   output logic                   eth_irq_o
);

   localparam int DW    = eth_na_pkg::DATA_W;
   localparam int TXC_W = $clog2(TX_DEPTH + 1);
   localparam int RXC_W = $clog2(RX_DEPTH + 1);

   logic                   wr_hs, rd_hs, bvalid_q, rvalid_q;
   eth_na_pkg::axi_resp_e  bresp_q, rresp_q, wr_resp, rd_resp;
   logic [DW-1:0]          rdata_q, rd_data;
   logic [2:0]             isr_q, ier_q, isr_set, isr_clr;
   logic [TXC_W-1:0]       tx_count, frame_cnt_q;
   logic [RXC_W-1:0]       rx_count;
   logic                   tx_full, rx_full, rx_empty;
   logic                   tx_push, tx_last_wr, tx_pop, rx_push, rx_pop, ier_we;
   eth_na_pkg::axis_word_t rx_head;

   assign wr_hs      = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
   assign rd_hs      = axil_req_i.arvalid && !rvalid_q;
   assign tx_last_wr = (axil_req_i.awaddr[7:0] == eth_na_pkg::REG_TX_LAST);
   assign tx_valid_o = (frame_cnt_q != '0);           // complete frame queued
   assign tx_pop     = tx_valid_o && tx_ready_i;
   assign rx_push    = rx_valid_i && !rx_full;        // no backpressure toward MII
   assign eth_irq_o  = |(isr_q & ier_q);

   always_comb begin
      wr_resp = eth_na_pkg::OKAY;
      tx_push = 1'b0;
      isr_clr = '0;
      ier_we  = 1'b0;
      case (axil_req_i.awaddr[7:0])
         eth_na_pkg::REG_ISR:
            isr_clr = axil_req_i.wdata[2:0];
         eth_na_pkg::REG_IER:
            ier_we = 1'b1;
         eth_na_pkg::REG_TX_DATA, eth_na_pkg::REG_TX_LAST: begin
            if (tx_full)
               wr_resp = eth_na_pkg::SLVERR;         // word dropped
            else
               tx_push = wr_hs;
         end
         default:
            wr_resp = eth_na_pkg::SLVERR;
      endcase
      if (!wr_hs) begin
         isr_clr = '0;
         ier_we  = 1'b0;
      end
   end

   always_comb begin
      rd_resp = eth_na_pkg::OKAY;
      rd_data = '0;
      rx_pop  = 1'b0;
      case (axil_req_i.araddr[7:0])
         eth_na_pkg::REG_ISR:
            rd_data[2:0] = isr_q;
         eth_na_pkg::REG_IER:
            rd_data[2:0] = ier_q;
         eth_na_pkg::REG_TX_VAC:
            rd_data = DW'(TX_DEPTH) - DW'(tx_count);
         eth_na_pkg::REG_RX_OCC: begin
            rd_data[15:0] = 16'(rx_count);
            rd_data[31]   = !rx_empty && rx_head.last;
         end
         eth_na_pkg::REG_RX_DATA: begin
            if (rx_empty) begin
               rd_resp = eth_na_pkg::SLVERR;
            end else begin
               rd_data = rx_head.data;
               rx_pop  = rd_hs;
            end
         end
         default:
            rd_resp = eth_na_pkg::SLVERR;
      endcase
   end

   always_comb begin
      isr_set = '0;
      isr_set[eth_na_pkg::ISR_RX_DONE] = rx_valid_i && rx_word_i.last;
      isr_set[eth_na_pkg::ISR_TX_DONE] = tx_done_i;
      isr_set[eth_na_pkg::ISR_RX_OVF]  = rx_valid_i && rx_full;
   end

   always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bvalid_q    <= 1'b0;
         rvalid_q    <= 1'b0;
         isr_q       <= '0;
         ier_q       <= '0;
         frame_cnt_q <= '0;
      end else begin
         if (wr_hs)
            bvalid_q <= 1'b1;
         else if (axil_req_i.bready)
            bvalid_q <= 1'b0;
         if (rd_hs)
            rvalid_q <= 1'b1;
         else if (axil_req_i.rready)
            rvalid_q <= 1'b0;
         isr_q <= (isr_q & ~isr_clr) | isr_set;      // a new event wins over the clear
         if (ier_we)
            ier_q <= axil_req_i.wdata[2:0];
         frame_cnt_q <= frame_cnt_q + TXC_W'(tx_push && tx_last_wr)
                        - TXC_W'(tx_pop && tx_word_o.last);
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (wr_hs)
         bresp_q <= wr_resp;
      if (rd_hs) begin
         rresp_q <= rd_resp;
         rdata_q <= rd_data;
      end
   end

   always_comb begin
      axil_rsp_o.awready = wr_hs;
      axil_rsp_o.wready  = wr_hs;
      axil_rsp_o.bresp   = bresp_q;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.arready = !rvalid_q;
      axil_rsp_o.rdata   = rdata_q;
      axil_rsp_o.rresp   = rresp_q;
      axil_rsp_o.rvalid  = rvalid_q;
   end

   sync_fifo #(.DEPTH(TX_DEPTH)) u_tx_fifo (
      .sys_clk_i   (sys_clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (tx_push),
      .push_word_i ('{data: axil_req_i.wdata, last: tx_last_wr}),
      .pop_i       (tx_pop),
      .head_o      (tx_word_o),
      .full_o      (tx_full),
      .empty_o     (),
      .count_o     (tx_count)
   );

   sync_fifo #(.DEPTH(RX_DEPTH)) u_rx_fifo (
      .sys_clk_i   (sys_clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (rx_push),
      .push_word_i (rx_word_i),
      .pop_i       (rx_pop),
      .head_o      (rx_head),
      .full_o      (rx_full),
      .empty_o     (rx_empty),
      .count_o     (rx_count)
   );

   // each counted frame still has its last word queued
   assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      frame_cnt_q <= tx_count);

endmodule

// File: source/eth_na_top.sv
// network adapter top; MII runs on sys_clk_i, frames are whole words, one Wishbone data port only
`timescale 1ns/1ps

module eth_na_top #(
   parameter int TX_DEPTH = 32,
   parameter int RX_DEPTH = 16
) (
   input  logic                sys_clk_i,
   input  logic                rst_n_i,
   input  eth_na_pkg::wb_req_t wb_req_i,
   output eth_na_pkg::wb_rsp_t wb_rsp_o,
   output logic                eth_irq_o,
   output logic [3:0]          phy_mii_txd_o,
   output logic                phy_mii_tx_en_o,
   input  logic [3:0]          phy_mii_rxd_i,
   input  logic                phy_mii_rx_dv_i
);

   eth_na_pkg::axil_req_t  axil_req;
   eth_na_pkg::axil_rsp_t  axil_rsp;
   eth_na_pkg::axis_word_t tx_word;
   eth_na_pkg::axis_word_t rx_word;
   logic                   tx_valid;
   logic                   tx_ready;
   logic                   tx_done;
   logic                   rx_valid;

   wb_axil_bridge u_bridge (
      .sys_clk_i  (sys_clk_i),
      .rst_n_i    (rst_n_i),
      .wb_req_i   (wb_req_i),
      .wb_rsp_o   (wb_rsp_o),
      .axil_req_o (axil_req),
      .axil_rsp_i (axil_rsp)
   );

   axil_stream_fifo #(
      .TX_DEPTH (TX_DEPTH),
      .RX_DEPTH (RX_DEPTH)
   ) u_stream_fifo (
      .sys_clk_i  (sys_clk_i),
      .rst_n_i    (rst_n_i),
      .axil_req_i (axil_req),
      .axil_rsp_o (axil_rsp),
      .tx_word_o  (tx_word),
      .tx_valid_o (tx_valid),
      .tx_ready_i (tx_ready),
      .tx_done_i  (tx_done),
      .rx_word_i  (rx_word),
      .rx_valid_i (rx_valid),
      .eth_irq_o  (eth_irq_o)
   );

   mii_tx u_mii_tx (
      .sys_clk_i   (sys_clk_i),
      .rst_n_i     (rst_n_i),
      .tx_word_i   (tx_word),
      .tx_valid_i  (tx_valid),
      .tx_ready_o  (tx_ready),
      .tx_done_o   (tx_done),
      .mii_txd_o   (phy_mii_txd_o),
      .mii_tx_en_o (phy_mii_tx_en_o)
   );

   mii_rx u_mii_rx (
      .sys_clk_i   (sys_clk_i),
      .rst_n_i     (rst_n_i),
      .mii_rxd_i   (phy_mii_rxd_i),
      .mii_rx_dv_i (phy_mii_rx_dv_i),
      .rx_word_o   (rx_word),
      .rx_valid_o  (rx_valid)
   );

endmodule

// File: tests/eth_na_tb.sv
// loopback testbench; expects the default FIFO depths, MII transmit pins feed the receive pins
`timescale 1ns/1ps

module eth_na_tb;

   localparam int TX_DEPTH    = 32;
   localparam int RX_DEPTH    = 16;
   localparam int BUS_TIMEOUT = 64;     // cycles per Wishbone transfer
   localparam int POLL_LIMIT  = 500;    // ISR reads per frame

   typedef struct packed {
      logic [5:0]  len;                 // frame length in words
      logic        ier_en;              // enable the RX_DONE interrupt
      logic [31:0] exp_occ;             // first RX_OCC read after the frame
      logic [2:0]  exp_isr;
      logic        exp_err;             // extra RX_DATA read once drained
   } entry_t;

   logic                sys_clk;
   logic                rst_n;
   eth_na_pkg::wb_req_t wb_req;
   eth_na_pkg::wb_rsp_t wb_rsp;
   logic                eth_irq;
   logic [3:0]          mii_txd;
   logic                mii_tx_en;
   entry_t              stim [6];
   logic [31:0]         frame_words [32];

   eth_na_top eth_na_top_i (
      .sys_clk_i       (sys_clk),
      .rst_n_i         (rst_n),
      .wb_req_i        (wb_req),
      .wb_rsp_o        (wb_rsp),
      .eth_irq_o       (eth_irq),
      .phy_mii_txd_o   (mii_txd),
      .phy_mii_tx_en_o (mii_tx_en),
      .phy_mii_rxd_i   (mii_txd),       // loopback
      .phy_mii_rx_dv_i (mii_tx_en)
   );

   initial begin
      sys_clk = 1'b0;
      forever #2 sys_clk = ~sys_clk;
   end

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic report_timeout(input string what);
      $display("timed out waiting for %s", what);
      abort_run();
   endtask

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
         abort_run();
      end
   endtask

   function automatic logic [31:0] reg_offset(input eth_na_pkg::reg_addr_e r);
      return 32'(r);
   endfunction

   // one classic transfer, driven and sampled on falling edges
   task automatic access_bus(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat, output logic err);
      int waited;
      waited = 0;
      @(negedge sys_clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      @(negedge sys_clk);
      while (!(wb_rsp.ack || wb_rsp.err)) begin
         if (waited == BUS_TIMEOUT)
            report_timeout($sformatf("a Wishbone response at address 0x%08h", adr));
         waited++;
         @(negedge sys_clk);
      end
      rdat   = wb_rsp.dat;
      err    = wb_rsp.err;
      wb_req = '0;                      // released before the bridge returns to IDLE
   endtask

   task automatic write_reg(input logic [31:0] adr, input logic [31:0] wdat,
                            input logic exp_err);
      logic [31:0] unused;
      logic        err;
      access_bus(1'b1, adr, wdat, unused, err);
      check_equal($sformatf("wb_rsp_o.err (write 0x%02h)", adr[7:0]), 32'(err), 32'(exp_err));
   endtask

   task automatic read_reg(input logic [31:0] adr, input logic exp_err,
                           output logic [31:0] rdat);
      logic err;
      access_bus(1'b0, adr, 32'd0, rdat, err);
      check_equal($sformatf("wb_rsp_o.err (read 0x%02h)", adr[7:0]), 32'(err), 32'(exp_err));
   endtask

   task automatic wait_frame_done();
      logic [31:0] isr;
      int          polls;
      polls = 0;
      read_reg(reg_offset(eth_na_pkg::REG_ISR), 1'b0, isr);
      while (!(isr[eth_na_pkg::ISR_RX_DONE] && isr[eth_na_pkg::ISR_TX_DONE])) begin
         if (polls == POLL_LIMIT)
            report_timeout("the frame to be sent and received");
         polls++;
         read_reg(reg_offset(eth_na_pkg::REG_ISR), 1'b0, isr);
      end
   endtask

   task automatic run_entry(input entry_t e);
      logic [31:0] rdat;
      logic [31:0] exp_occ;
      logic [31:0] ier_val;
      int          kept;
      logic        last_kept;
      kept      = (e.len > RX_DEPTH) ? RX_DEPTH : int'(e.len);
      last_kept = (e.len <= RX_DEPTH);  // final word is lost on overflow
      ier_val   = e.ier_en ? (32'd1 << eth_na_pkg::ISR_RX_DONE) : 32'd0;
      write_reg(reg_offset(eth_na_pkg::REG_IER), ier_val, 1'b0);
      for (int i = 0; i < e.len; i++) begin
         frame_words[i] = $urandom;
         write_reg(reg_offset(i == e.len - 1 ? eth_na_pkg::REG_TX_LAST : eth_na_pkg::REG_TX_DATA),
                   frame_words[i], 1'b0);
      end
      wait_frame_done();
      read_reg(reg_offset(eth_na_pkg::REG_ISR), 1'b0, rdat);
      check_equal("ISR", rdat, 32'(e.exp_isr));
      check_equal("eth_irq_o", 32'(eth_irq), 32'(e.ier_en));
      if (e.ier_en) begin
         write_reg(reg_offset(eth_na_pkg::REG_ISR), ier_val, 1'b0);
         check_equal("eth_irq_o", 32'(eth_irq), 32'd0);
      end
      write_reg(reg_offset(eth_na_pkg::REG_ISR), 32'h7, 1'b0);   // clear the rest
      read_reg(reg_offset(eth_na_pkg::REG_ISR), 1'b0, rdat);
      check_equal("ISR", rdat, 32'd0);
      read_reg(reg_offset(eth_na_pkg::REG_RX_OCC), 1'b0, rdat);
      check_equal("RX_OCC", rdat, e.exp_occ);
      for (int i = 0; i < kept; i++) begin
         exp_occ     = 32'(kept - i);
         exp_occ[31] = last_kept && (i == kept - 1);
         read_reg(reg_offset(eth_na_pkg::REG_RX_OCC), 1'b0, rdat);
         check_equal("RX_OCC", rdat, exp_occ);
         read_reg(reg_offset(eth_na_pkg::REG_RX_DATA), 1'b0, rdat);
         check_equal("RX_DATA", rdat, frame_words[i]);
      end
      read_reg(reg_offset(eth_na_pkg::REG_RX_DATA), e.exp_err, rdat);
      read_reg(reg_offset(eth_na_pkg::REG_TX_VAC), 1'b0, rdat);
      check_equal("TX_VAC", rdat, 32'(TX_DEPTH));
      write_reg(reg_offset(eth_na_pkg::REG_IER), 32'd0, 1'b0);
   endtask

   initial begin
      logic [31:0] rdat;
      wb_req = '0;
      rst_n  = 1'b0;
      void'($urandom(32'h9746));        // frame data seed
      stim[0] = '{len: 6'd1,  ier_en: 1'b0, exp_occ: 32'h8000_0001, exp_isr: 3'b011, exp_err: 1'b1};
      stim[1] = '{len: 6'd2,  ier_en: 1'b1, exp_occ: 32'h0000_0002, exp_isr: 3'b011, exp_err: 1'b1};
      stim[2] = '{len: 6'd5,  ier_en: 1'b0, exp_occ: 32'h0000_0005, exp_isr: 3'b011, exp_err: 1'b1};
      stim[3] = '{len: 6'd8,  ier_en: 1'b1, exp_occ: 32'h0000_0008, exp_isr: 3'b011, exp_err: 1'b1};
      stim[4] = '{len: 6'd3,  ier_en: 1'b1, exp_occ: 32'h0000_0003, exp_isr: 3'b011, exp_err: 1'b1};
      stim[5] = '{len: 6'd20, ier_en: 1'b0, exp_occ: 32'h0000_0010, exp_isr: 3'b111, exp_err: 1'b1};
      repeat (10) @(negedge sys_clk);
      rst_n = 1'b1;
      @(negedge sys_clk);
      check_equal("wb_rsp_o.ack", 32'(wb_rsp.ack), 32'd0);
      check_equal("wb_rsp_o.err", 32'(wb_rsp.err), 32'd0);
      check_equal("eth_irq_o", 32'(eth_irq), 32'd0);
      check_equal("phy_mii_tx_en_o", 32'(mii_tx_en), 32'd0);
      read_reg(reg_offset(eth_na_pkg::REG_ISR), 1'b0, rdat);
      check_equal("ISR", rdat, 32'd0);
      read_reg(reg_offset(eth_na_pkg::REG_TX_VAC), 1'b0, rdat);
      check_equal("TX_VAC", rdat, 32'(TX_DEPTH));
      // unmapped offset and empty RX FIFO
      read_reg(32'h0000_0008, 1'b1, rdat);
      write_reg(32'h0000_0008, 32'hFFFF_FFFF, 1'b1);
      read_reg(reg_offset(eth_na_pkg::REG_RX_DATA), 1'b1, rdat);
      foreach (stim[n])
         run_entry(stim[n]);
      $display("Regression passed");
      $finish;
   end

   initial begin
      #500_000;
      report_timeout("the run to finish");
   end

endmodule

// File: vlog.f
source/eth_na_pkg.sv
source/sync_fifo.sv
source/wb_axil_bridge.sv
source/mii_tx.sv
source/mii_rx.sv
source/axil_stream_fifo.sv
source/eth_na_top.sv
tests/eth_na_tb.sv
